// ==== Makefile ====
TOOL   := verilator
FLAGS  := --binary --timing -j 0
TOP    := tb_trace_unit
FLIST  := flist.f
OBJDIR := obj_dir

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST))
STIM    := tb/trace_stim.txt

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(SIM) $(STIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q '^Simulation passed$$'

clean:
	rm -rf $(OBJDIR)

// ==== flist.f ====
verilog/trace_pkg.sv
verilog/trace_cfg_if.sv
verilog/trace_decoder.sv
verilog/trace_buffer.sv
verilog/trace_csr_regs.sv
verilog/trace_unit.sv
tb/tb_trace_unit.sv

// ==== tb/tb_trace_unit.sv ====
/*
 * Testbench for the instruction trace unit
 * Replays the stim file through decode, filter, overflow under
 * back-pressure and Wishbone register checks
 */
module tb_trace_unit;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned BUF_DEPTH       = 4;
  localparam int unsigned CYCLES_PER_TEST = 200;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  rvfi_valid;
  logic [31:0]           rvfi_insn;
  logic [31:0]           rvfi_pc_rdata;
  logic [31:0]           rvfi_pc_wdata;
  logic                  trace_valid;
  trace_pkg::trace_rec_t trace_rec;
  logic                  trace_ready;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [1:0]            wb_adr;
  logic [31:0]           wb_dat_w;
  logic [31:0]           wb_dat_r;
  logic                  wb_ack;

  int          errors = 0;
  int          edge_cnt = 0;
  int          last_edge = 0;
  logic [31:0] last_cycle = '0;
  bit          have_stamp = 1'b0;
  logic [16:0] lfsr = 17'd89843;
  string       tests[$];
  bit          tests_loaded = 1'b0;

  trace_unit #(
    .BUF_DEPTH (BUF_DEPTH)
  ) UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rvfi_valid    (rvfi_valid),
    .rvfi_insn     (rvfi_insn),
    .rvfi_pc_rdata (rvfi_pc_rdata),
    .rvfi_pc_wdata (rvfi_pc_wdata),
    .trace_valid   (trace_valid),
    .trace_rec     (trace_rec),
    .trace_ready   (trace_ready),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack)
  );

  always #2 clk_i = ~clk_i;

  // Reference count of rising edges
  always @(posedge clk_i) edge_cnt <= edge_cnt + 1;

  // 17-bit Fibonacci LFSR, taps 17 and 14
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[16]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // Record as the decode rules define it, cycle left open
  function automatic trace_pkg::trace_rec_t expect_rec(input logic [31:0] insn, pc,
      input trace_pkg::trace_fmt_e fmt, input trace_pkg::trace_access_t acc,
      input logic [31:0] value);
    trace_pkg::trace_rec_t r;
    r            = '0;
    r.pc         = pc;
    r.compressed = (fmt == trace_pkg::FMT_C);
    r.insn       = r.compressed ? {16'h0, insn[15:0]} : insn;
    r.fmt        = fmt;
    r.access     = acc;
    r.value      = value;
    return r;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_fmt(input string name, input trace_pkg::trace_fmt_e got, exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_access(input string name, input trace_pkg::trace_access_t got, exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // Stamp is checked as a difference to the previous record seen
  task automatic check_rec(input trace_pkg::trace_rec_t got, exp, input int edge_no);
    check_word("trace_rec.pc", got.pc, exp.pc);
    check_word("trace_rec.insn", got.insn, exp.insn);
    check_fmt("trace_rec.fmt", got.fmt, exp.fmt);
    check_access("trace_rec.access", got.access, exp.access);
    check_word("trace_rec.value", got.value, exp.value);
    check_word("trace_rec.compressed", 32'(got.compressed), 32'(exp.compressed));
    if (have_stamp) begin
      check_word("trace_rec.cycle delta", got.cycle - last_cycle, edge_no - last_edge);
    end
    last_cycle = got.cycle;
    last_edge  = edge_no;
    have_stamp = 1'b1;
  endtask

  task automatic step();
    @(posedge clk_i);
    #0.5;
  endtask

  // One retirement, sampled at the next edge
  task automatic retire(input logic [31:0] insn, pc, pc_next, output int edge_no);
    rvfi_valid    = 1'b1;
    rvfi_insn     = insn;
    rvfi_pc_rdata = pc;
    rvfi_pc_wdata = pc_next;
    edge_no       = edge_cnt + 1;
    step();
    rvfi_valid = 1'b0;
  endtask

  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
      output logic [31:0] rdata, output int edge_no);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    edge_no  = edge_cnt + 1;
    waited   = 0;
    do begin
      step();
      waited++;
    end while (!wb_ack && waited < 2);
    rdata = wb_dat_r;
    if (!wb_ack) begin
      $display("Wishbone access to word %0d got no ack within 2 cycles", adr);
      errors++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    step();
    if (wb_ack !== 1'b0) begin
      $display("wb_ack stayed high for more than one cycle");
      errors++;
    end
  endtask

  // Empty buffer, so the record is at the head one cycle after retirement
  task automatic run_decode(input logic [31:0] insn, pc, pc_next, fmt, acc, value);
    trace_pkg::trace_rec_t exp;
    int e;
    exp = expect_rec(insn, pc, trace_pkg::trace_fmt_e'(fmt[3:0]),
                     trace_pkg::trace_access_t'(acc[3:0]), value);
    retire(insn, pc, pc_next, e);
    if (!trace_valid) begin
      $display("No trace record one cycle after instruction 0x%h", insn);
      errors++;
    end else begin
      check_rec(trace_rec, exp, e);
    end
    step();
  endtask

  task automatic run_skip(input logic [31:0] insn, pc, pc_next);
    int e;
    retire(insn, pc, pc_next, e);
    repeat (4) begin
      if (trace_valid) begin
        $display("A record appeared for instruction 0x%h that should be discarded", insn);
        errors++;
      end
      step();
    end
  endtask

  task automatic run_overflow(input int n);
    trace_pkg::trace_rec_t exp_q[$];
    int          edge_q[$];
    logic [31:0] imm;
    logic [31:0] rs1;
    logic [31:0] rd;
    logic [31:0] insn;
    logic [31:0] pc;
    int          e;
    int          k;
    trace_ready = 1'b0;
    for (int i = 0; i < n; i++) begin
      imm  = rand_bits(12);
      rs1  = rand_bits(5);
      rd   = rand_bits(5);
      insn = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], trace_pkg::OPC_OPIMM};
      pc   = 32'h1000 + 32'(4 * i);
      exp_q.push_back(expect_rec(insn, pc, trace_pkg::FMT_I, 4'b1010,
                                 {{20{imm[11]}}, imm[11:0]}));
      retire(insn, pc, pc + 32'd4, e);
      edge_q.push_back(e);
    end
    // Head must hold while stalled
    repeat (3) begin
      if (!trace_valid) begin
        $display("trace_valid dropped while trace_ready was held low");
        errors++;
      end else begin
        check_rec(trace_rec, exp_q[0], edge_q[0]);
      end
      step();
    end
    trace_ready = 1'b1;
    k = 0;
    for (int t = 0; t < 2 * BUF_DEPTH + 4; t++) begin
      if (trace_valid) begin
        if (k >= BUF_DEPTH || k >= n) begin
          $display("More records left the buffer than it can hold");
          errors++;
        end else begin
          check_rec(trace_rec, exp_q[k], edge_q[k]);
        end
        k++;
      end
      step();
    end
    if (k < BUF_DEPTH && k < n) begin
      $display("Only %0d records left the buffer after the stall", k);
      errors++;
    end
  endtask

  task automatic run_cycle_reads(input int gap);
    logic [31:0] c1;
    logic [31:0] c2;
    int          e1;
    int          e2;
    wb_access(1'b0, trace_pkg::REG_CYCLE, '0, c1, e1);
    repeat (gap) step();
    wb_access(1'b0, trace_pkg::REG_CYCLE, '0, c2, e2);
    check_word("REG_CYCLE delta", c2 - c1, e2 - e1);
  endtask

  // Watchdog sized from the number of stim lines
  initial begin
    wait (tests_loaded);
    repeat (tests.size() * CYCLES_PER_TEST + 64) @(posedge clk_i);
    $display("Watchdog expired before all %0d tests finished", tests.size());
    $display("Simulation failed");
    $finish;
  end

  initial begin
    string       line;
    string       kind;
    logic [31:0] f[6];
    logic [31:0] rdata;
    int          fd;
    int          n;
    int          e;
    int          err_before;
    int          passed;
    int          failed;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    rvfi_valid    = 1'b0;
    rvfi_insn     = '0;
    rvfi_pc_rdata = '0;
    rvfi_pc_wdata = '0;
    trace_ready   = 1'b0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    passed        = 0;
    failed        = 0;

    fd = $fopen("tb/trace_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file tb/trace_stim.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s", kind);
        if (n == 1 && kind != "#") tests.push_back(line);
      end
      $fclose(fd);
    end
    tests_loaded = 1'b1;

    repeat (16) @(posedge clk_i);
    #0.5;
    rst_ni = 1'b1;
    step();
    if (trace_valid !== 1'b0) begin
      $display("trace_valid is not low after reset");
      errors++;
    end
    trace_ready = 1'b1;

    foreach (tests[i]) begin
      err_before = errors;
      n = $sscanf(tests[i], "%s %h %h %h %h %h %h", kind, f[0], f[1], f[2], f[3], f[4], f[5]);
      case (kind)
        "dec":  run_decode(f[0], f[1], f[2], f[3], f[4], f[5]);
        "skip": run_skip(f[0], f[1], f[2]);
        "ovf":  run_overflow(int'(f[0]));
        "cyc":  run_cycle_reads(int'(f[0]));
        "wr":   wb_access(1'b1, f[0][1:0], f[1], rdata, e);
        "rd": begin
          wb_access(1'b0, f[0][1:0], '0, rdata, e);
          check_word("wb_dat_r", rdata, f[1]);
        end
        default: begin
          $display("Unknown test kind '%s' on stim line %0d", kind, i + 1);
          errors++;
        end
      endcase
      if (errors == err_before) begin
        passed++;
        $display("Test %0d (%s) passed", i + 1, kind);
      end else begin
        failed++;
        $display("Test %0d (%s) FAILED", i + 1, kind);
      end
    end

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests.size(), passed, failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== tb/trace_stim.txt ====
# dec insn pc pc_next fmt access value | skip insn pc pc_next | rd addr expect | wr addr data
# ovf retire_count | cyc idle_cycles | all hex, access bits are rs1 rs2 rd mem from msb
rd   0 0001ff00
rd   1 00000000
skip 00a00093 00000100 00000104
wr   0 0001ff01
dec  002081b3 00000100 00000104 0 e 00000000
dec  fff00093 00000104 00000108 1 a ffffffff
dec  00812283 00000108 0000010c 1 b 00000008
dec  fe612e23 0000010c 00000110 2 d fffffffc
dec  fe208ce3 00000200 00000204 3 c 000001f8
dec  123452b7 00000204 00000208 4 2 00012345
dec  008000ef 00000300 00000308 5 2 00000308
dec  300110f3 00000308 0000030c 6 a 00000300
dec  3002d0f3 0000030c 00000310 6 2 00000300
dec  00000073 00000310 00000314 6 0 00000000
dec  dead0085 00000314 00000316 7 0 00000000
dec  0000000b 00000316 0000031a 8 0 00000000
wr   0 00017e01
dec  00a00093 00000400 00000404 1 a 0000000a
skip 002081b3 00000404 00000408
dec  00112023 00000408 0000040c 2 d 00000000
skip 00004505 0000040c 0000040e
dec  000012b7 0000040e 00000412 4 2 00000001
rd   1 00000000
wr   0 0001ff01
ovf  7
rd   1 00000003
wr   1 00000000
rd   1 00000000
cyc  5

// ==== verilog/trace_buffer.sv ====
/*
 * Trace record buffer
 * Filters records by enable and format mask, queues them in a circular
 * FIFO and reports every accepted record lost to a full FIFO
 */
module trace_buffer #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push,
  input  trace_pkg::trace_rec_t rec_in,
  trace_cfg_if.buffer           cfg,
  output logic                  trace_valid,
  output trace_pkg::trace_rec_t trace_rec,
  input  logic                  trace_ready
);

  // DEPTH is a power of two, pointers wrap on their own
  localparam int unsigned AW = $clog2(DEPTH);

  trace_pkg::trace_rec_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          accept;
  logic          full;
  logic          pop;
  logic          wr_en;

  assign accept = push & cfg.enable & cfg.fmt_mask[rec_in.fmt];
  assign full   = (count == (AW + 1)'(DEPTH));
  assign pop    = trace_valid & trace_ready;

  // A pop in the same cycle frees the slot for the incoming record
  assign wr_en  = accept & (~full | pop);

  assign cfg.drop_pulse = accept & full & ~pop;

  assign trace_valid = (count != '0);
  assign trace_rec   = mem[rd_ptr];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (wr_en && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_ptr] <= rec_in;
    end
  end

endmodule

// ==== verilog/trace_cfg_if.sv ====
/*
 * Trace configuration and status link
 * Carries enable, filter mask and cycle count out of the register
 * block and the drop pulse back from the record buffer
 */
interface trace_cfg_if;

  logic                                   enable;
  logic [trace_pkg::TRACE_FMT_NUM-1:0]    fmt_mask;
  logic [31:0]                            cycle;
  logic                                   drop_pulse;

  modport regs (
    output enable,
    output fmt_mask,
    output cycle,
    input  drop_pulse
  );

  modport buffer (
    input  enable,
    input  fmt_mask,
    output drop_pulse
  );

  // Decoder only needs the time stamp
  modport stamp (
    input  cycle
  );

endinterface

// ==== verilog/trace_csr_regs.sv ====
/*
 * Trace control registers on a Wishbone classic slave
 * Holds enable and filter mask, the saturating drop count and the
 * free-running cycle counter
 */
module trace_csr_regs (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [1:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  trace_cfg_if.regs   cfg
);

  localparam int unsigned MASK_MSB = trace_pkg::CTRL_MASK_LSB + trace_pkg::TRACE_FMT_NUM - 1;

  logic        access;
  logic        wr_ctrl;
  logic        wr_status;
  logic [15:0] drop_cnt;
  logic [31:0] ctrl_word;
  logic [31:0] rd_data;

  // Registered once per strobe, ack blocks the following cycle
  assign access    = wb_cyc & wb_stb & ~wb_ack;
  assign wr_ctrl   = access & wb_we & (wb_adr == trace_pkg::REG_CTRL);
  assign wr_status = access & wb_we & (wb_adr == trace_pkg::REG_STATUS);

  always_comb begin
    ctrl_word                                   = '0;
    ctrl_word[0]                                = cfg.enable;
    ctrl_word[MASK_MSB:trace_pkg::CTRL_MASK_LSB] = cfg.fmt_mask;
  end

  always_comb begin
    case (wb_adr)
      trace_pkg::REG_CTRL:   rd_data = ctrl_word;
      trace_pkg::REG_STATUS: rd_data = {16'b0, drop_cnt};
      trace_pkg::REG_CYCLE:  rd_data = cfg.cycle;
      default:               rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack       <= 1'b0;
      cfg.enable   <= 1'b0;
      cfg.fmt_mask <= '1;
    end else begin
      wb_ack <= access;
      if (wr_ctrl) begin
        cfg.enable   <= wb_dat_w[0];
        cfg.fmt_mask <= wb_dat_w[MASK_MSB:trace_pkg::CTRL_MASK_LSB];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      wb_dat_r <= rd_data;
    end
  end

  // Drop count, a clear takes priority over a new drop
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      drop_cnt <= '0;
    end else if (wr_status) begin
      drop_cnt <= '0;
    end else if (cfg.drop_pulse && drop_cnt != '1) begin
      drop_cnt <= drop_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg.cycle <= '0;
    end else begin
      cfg.cycle <= cfg.cycle + 1'b1;
    end
  end

endmodule

// ==== verilog/trace_decoder.sv ====
/*
 * Trace decoder
 * Classifies a retired instruction by encoding format, derives the
 * operand access mask and the per-format value, stamps the record
 */
module trace_decoder (
  input  logic [31:0]           insn,
  input  logic [31:0]           pc,
  input  logic [31:0]           pc_next,
  trace_cfg_if.stamp            cfg,
  output trace_pkg::trace_rec_t rec
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] csr_addr;
  logic        is_compressed;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];

  // Immediates of the base formats
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {12'b0, insn[31:12]};

  assign csr_addr = {20'b0, insn[31:20]};

  // Anything without 11 in the low bits is a 16-bit encoding
  assign is_compressed = (insn[1:0] != 2'b11);

  always_comb begin
    rec.cycle      = cfg.cycle;
    rec.pc         = pc;
    rec.insn       = insn;
    rec.fmt        = trace_pkg::FMT_INVALID;
    rec.access     = '0;
    rec.value      = '0;
    rec.compressed = 1'b0;

    if (is_compressed) begin
      // No operand decoding for the C extension
      rec.insn       = {16'b0, insn[15:0]};
      rec.fmt        = trace_pkg::FMT_C;
      rec.compressed = 1'b1;
    end else begin
      case (opcode)
        trace_pkg::OPC_OP: begin
          rec.fmt        = trace_pkg::FMT_R;
          rec.access.rs1 = 1'b1;
          rec.access.rs2 = 1'b1;
          rec.access.rd  = 1'b1;
        end
        trace_pkg::OPC_OPIMM,
        trace_pkg::OPC_JALR: begin
          rec.fmt        = trace_pkg::FMT_I;
          rec.access.rs1 = 1'b1;
          rec.access.rd  = 1'b1;
          rec.value      = imm_i;
        end
        trace_pkg::OPC_LOAD: begin
          rec.fmt        = trace_pkg::FMT_I;
          rec.access.rs1 = 1'b1;
          rec.access.rd  = 1'b1;
          rec.access.mem = 1'b1;
          rec.value      = imm_i;
        end
        trace_pkg::OPC_STORE: begin
          rec.fmt        = trace_pkg::FMT_S;
          rec.access.rs1 = 1'b1;
          rec.access.rs2 = 1'b1;
          rec.access.mem = 1'b1;
          rec.value      = imm_s;
        end
        trace_pkg::OPC_BRANCH: begin
          // Taken target, pc_next may be the fall-through address
          rec.fmt        = trace_pkg::FMT_B;
          rec.access.rs1 = 1'b1;
          rec.access.rs2 = 1'b1;
          rec.value      = pc + imm_b;
        end
        trace_pkg::OPC_LUI,
        trace_pkg::OPC_AUIPC: begin
          rec.fmt       = trace_pkg::FMT_U;
          rec.access.rd = 1'b1;
          rec.value     = imm_u;
        end
        trace_pkg::OPC_JAL: begin
          rec.fmt       = trace_pkg::FMT_J;
          rec.access.rd = 1'b1;
          rec.value     = pc_next;
        end
        trace_pkg::OPC_SYSTEM: begin
          rec.fmt = trace_pkg::FMT_SYS;
          if (funct3 != 3'b000) begin
            // CSR access, funct3[2] selects the immediate variants
            rec.access.rd  = 1'b1;
            rec.access.rs1 = ~funct3[2];
            rec.value      = csr_addr;
          end
        end
        trace_pkg::OPC_MISC_MEM: begin
          rec.fmt = trace_pkg::FMT_SYS;
        end
        default: begin
          rec.fmt = trace_pkg::FMT_INVALID;
        end
      endcase
    end
  end

endmodule

// ==== verilog/trace_pkg.sv ====
/*
 * Instruction trace unit shared definitions
 * Format classes, access flags, the trace record, RV32 major opcodes
 * and the register map of the control block
 */
package trace_pkg;

  // Encoding class of a retired instruction
  typedef enum logic [3:0] {
    FMT_R       = 4'd0,
    FMT_I       = 4'd1,
    FMT_S       = 4'd2,
    FMT_B       = 4'd3,
    FMT_U       = 4'd4,
    FMT_J       = 4'd5,
    FMT_SYS     = 4'd6,
    FMT_C       = 4'd7,
    FMT_INVALID = 4'd8
  } trace_fmt_e;

  // One filter bit per format class
  localparam int unsigned TRACE_FMT_NUM = 9;

  // Operands touched by the instruction
  typedef struct packed {
    logic rs1;
    logic rs2;
    logic rd;
    logic mem;
  } trace_access_t;

  typedef struct packed {
    logic [31:0]   cycle;
    logic [31:0]   pc;
    logic [31:0]   insn;        // upper half zero when compressed
    trace_fmt_e    fmt;
    trace_access_t access;
    logic [31:0]   value;       // immediate, target or CSR address
    logic          compressed;
  } trace_rec_t;

  // RV32 base major opcodes
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

  // Register map, word offsets
  localparam logic [1:0] REG_CTRL   = 2'd0;
  localparam logic [1:0] REG_STATUS = 2'd1;
  localparam logic [1:0] REG_CYCLE  = 2'd2;

  // Control register layout: enable at bit 0, filter mask from here up
  localparam int unsigned CTRL_MASK_LSB = 8;

endpackage

// ==== verilog/trace_unit.sv ====
/*
 * Instruction trace unit top level
 * Decodes retirements into stamped records, buffers them onto a
 * ready/valid stream and exposes control over Wishbone
 */
module trace_unit #(
  parameter int unsigned BUF_DEPTH = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Core retirement port
  input  logic                  rvfi_valid,
  input  logic [31:0]           rvfi_insn,
  input  logic [31:0]           rvfi_pc_rdata,
  input  logic [31:0]           rvfi_pc_wdata,

  // Record stream
  output logic                  trace_valid,
  output trace_pkg::trace_rec_t trace_rec,
  input  logic                  trace_ready,

  // Wishbone classic slave
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [1:0]            wb_adr,
  input  logic [31:0]           wb_dat_w,
  output logic [31:0]           wb_dat_r,
  output logic                  wb_ack
);

  trace_pkg::trace_rec_t dec_rec;

  trace_cfg_if cfg_if ();

  trace_decoder u_decoder (
    .insn    (rvfi_insn),
    .pc      (rvfi_pc_rdata),
    .pc_next (rvfi_pc_wdata),
    .cfg     (cfg_if.stamp),
    .rec     (dec_rec)
  );

  trace_buffer #(
    .DEPTH (BUF_DEPTH)
  ) u_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push        (rvfi_valid),
    .rec_in      (dec_rec),
    .cfg         (cfg_if.buffer),
    .trace_valid (trace_valid),
    .trace_rec   (trace_rec),
    .trace_ready (trace_ready)
  );

  trace_csr_regs u_regs (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .cfg      (cfg_if.regs)
  );

endmodule
